//--- logic/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ##########################################################################
// Address widths
// ##########################################################################

`define VIRTUAL_ADDR_WIDTH 16   // Virtual word address.
`define PHYSICAL_ADDR_WIDTH 12  // Physical word address.
`define PAGE_OFFSET_WIDTH 6     // Kept unchanged through translation.

`define REG_WIDTH 32            // Data word.

// ##########################################################################
// Buffer sizes and memory timing
// ##########################################################################

`define NUM_TLB_ENTRIES 4
`define CACHE_INDEX_WIDTH 3     // Eight direct-mapped lines.

// Cycles from an accepted memory request to its response.
`define MEM_LATENCY 3

`endif

//--- logic/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

    // ######################################################################
    // Vector types
    // ######################################################################

    typedef logic [`VIRTUAL_ADDR_WIDTH-1:0] vaddr_t;
    typedef logic [`PHYSICAL_ADDR_WIDTH-1:0] paddr_t;
    typedef logic [`VIRTUAL_ADDR_WIDTH-`PAGE_OFFSET_WIDTH-1:0] vpn_t;
    typedef logic [`PHYSICAL_ADDR_WIDTH-`PAGE_OFFSET_WIDTH-1:0] ppn_t;
    typedef logic [`REG_WIDTH-1:0] word_t;

    typedef logic [`CACHE_INDEX_WIDTH-1:0] cache_index_t;
    typedef logic [`PHYSICAL_ADDR_WIDTH-`CACHE_INDEX_WIDTH-1:0] cache_tag_t;

    // Cache controller states.
    typedef enum logic [1:0] {
        CACHE_IDLE,     // Waiting for a request.
        CACHE_MEM_REQ,  // Request held on the memory bus.
        CACHE_MEM_WAIT, // Accepted, response pending.
        CACHE_DONE      // Completion cycle.
    } cache_state_t;

endpackage

//--- logic/cpu_tlb.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_tlb (
    input  logic          clock,
    input  logic          rst,
    input  logic          write,
    input  cpu_pkg::vpn_t write_vpn,
    input  cpu_pkg::ppn_t write_ppn,
    input  cpu_pkg::vpn_t lookup_vpn,
    output logic          hit,
    output cpu_pkg::ppn_t ppn
);

    localparam int PTR_WIDTH = $clog2(`NUM_TLB_ENTRIES);

    logic [`NUM_TLB_ENTRIES-1:0] entry_valid;
    cpu_pkg::vpn_t entry_vpn [0:`NUM_TLB_ENTRIES-1];
    cpu_pkg::ppn_t entry_ppn [0:`NUM_TLB_ENTRIES-1];

    logic [PTR_WIDTH-1:0] fill_ptr;     // Round-robin victim.
    logic [PTR_WIDTH-1:0] match_index;
    logic [PTR_WIDTH-1:0] write_index;
    logic                 write_match;

    always_comb begin
        hit = 1'b0;
        ppn = '0;
        for (int i = 0; i < `NUM_TLB_ENTRIES; i++) begin
            if (entry_valid[i] && entry_vpn[i] == lookup_vpn) begin
                hit = 1'b1;
                ppn = entry_ppn[i];
            end
        end
    end

    // A vpn already present is overwritten in place.
    always_comb begin
        write_match = 1'b0;
        match_index = '0;
        for (int i = 0; i < `NUM_TLB_ENTRIES; i++) begin
            if (entry_valid[i] && entry_vpn[i] == write_vpn) begin
                write_match = 1'b1;
                match_index = PTR_WIDTH'(i);
            end
        end
    end

    assign write_index = write_match ? match_index : fill_ptr;

    always_ff @(posedge clock) begin
        if (rst) begin
            entry_valid <= '0;
            fill_ptr    <= '0;
        end else if (write) begin
            entry_valid[write_index] <= 1'b1;
            if (!write_match) begin
                fill_ptr <= (fill_ptr == PTR_WIDTH'(`NUM_TLB_ENTRIES - 1)) ? '0 : fill_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write) begin
            entry_vpn[write_index] <= write_vpn;
            entry_ppn[write_index] <= write_ppn;
        end
    end

endmodule

//--- logic/cpu_cache.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_cache (
    input  logic            clock,
    input  logic            rst,

    // Request from the commit unit.
    input  logic            req_read,
    input  logic            req_write,
    input  cpu_pkg::paddr_t req_addr,
    input  cpu_pkg::word_t  req_data,
    output logic            done,
    output logic            hit,
    output cpu_pkg::word_t  rdata,

    // Memory bus master.
    output logic            mem_req_valid,
    output logic            mem_req_write,
    output cpu_pkg::paddr_t mem_req_addr,
    output cpu_pkg::word_t  mem_req_data,
    input  logic            mem_bus_available,
    input  logic            mem_resp_valid,
    input  cpu_pkg::word_t  mem_resp_data
);

    localparam int NUM_LINES = 1 << `CACHE_INDEX_WIDTH;

    cpu_pkg::cache_state_t state;
    cpu_pkg::cache_state_t state_next;

    logic [NUM_LINES-1:0] line_valid;
    cpu_pkg::cache_tag_t  tag_array  [0:NUM_LINES-1];
    cpu_pkg::word_t       data_array [0:NUM_LINES-1];

    cpu_pkg::cache_index_t req_index;
    cpu_pkg::cache_tag_t   req_tag;
    cpu_pkg::cache_index_t fill_index;
    cpu_pkg::cache_tag_t   fill_tag;
    logic                  lookup_hit;
    logic                  read_hit;
    logic                  accept;
    logic                  fill;

    cpu_pkg::paddr_t addr_q;
    cpu_pkg::word_t  data_q;
    cpu_pkg::word_t  rdata_q;
    logic            write_q;
    logic            hit_q;

    assign req_index  = req_addr[`CACHE_INDEX_WIDTH-1:0];
    assign req_tag    = req_addr[`PHYSICAL_ADDR_WIDTH-1:`CACHE_INDEX_WIDTH];
    assign fill_index = addr_q[`CACHE_INDEX_WIDTH-1:0];
    assign fill_tag   = addr_q[`PHYSICAL_ADDR_WIDTH-1:`CACHE_INDEX_WIDTH];

    assign lookup_hit = line_valid[req_index] && tag_array[req_index] == req_tag;
    assign read_hit   = req_read && !req_write && lookup_hit; // Write wins if both.
    assign accept     = state == cpu_pkg::CACHE_IDLE && (req_read || req_write);
    assign fill       = state == cpu_pkg::CACHE_MEM_WAIT && mem_resp_valid && !write_q;

    // ######################################################################
    // Controller
    // ######################################################################

    always_comb begin
        state_next = state;
        case (state)
            cpu_pkg::CACHE_IDLE: begin
                if (read_hit) begin
                    state_next = cpu_pkg::CACHE_DONE;
                end else if (req_read || req_write) begin
                    state_next = cpu_pkg::CACHE_MEM_REQ;
                end
            end
            cpu_pkg::CACHE_MEM_REQ: begin
                if (mem_bus_available) begin
                    state_next = cpu_pkg::CACHE_MEM_WAIT;
                end
            end
            cpu_pkg::CACHE_MEM_WAIT: begin
                if (mem_resp_valid) begin
                    state_next = cpu_pkg::CACHE_DONE;
                end
            end
            default: state_next = cpu_pkg::CACHE_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state      <= cpu_pkg::CACHE_IDLE;
            line_valid <= '0;
        end else begin
            state <= state_next;
            if (fill) begin
                line_valid[fill_index] <= 1'b1;
            end
        end
    end

    // ######################################################################
    // Line arrays and request registers
    // ######################################################################

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q  <= req_addr;
            data_q  <= req_data;
            write_q <= req_write;
            hit_q   <= lookup_hit;
            if (read_hit) begin
                rdata_q <= data_array[req_index];
            end
            if (req_write && lookup_hit) begin
                data_array[req_index] <= req_data; // Write hit keeps the line current.
            end
        end
        if (fill) begin
            rdata_q                <= mem_resp_data;
            data_array[fill_index] <= mem_resp_data;
            tag_array[fill_index]  <= fill_tag;
        end
    end

    assign done  = state == cpu_pkg::CACHE_DONE;
    assign hit   = (state == cpu_pkg::CACHE_IDLE) ? lookup_hit : hit_q;
    assign rdata = rdata_q;

    assign mem_req_valid = state == cpu_pkg::CACHE_MEM_REQ;
    assign mem_req_write = write_q;
    assign mem_req_addr  = addr_q;
    assign mem_req_data  = data_q;

endmodule

//--- logic/cpu_main_memory.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_main_memory (
    input  logic            clock,
    input  logic            rst,
    input  logic            mem_req_valid,
    input  logic            mem_req_write,
    input  cpu_pkg::paddr_t mem_req_addr,
    input  cpu_pkg::word_t  mem_req_data,
    output logic            mem_bus_available,
    output logic            mem_resp_valid,
    output cpu_pkg::word_t  mem_resp_data
);

    localparam int DEPTH       = 1 << `PHYSICAL_ADDR_WIDTH;
    localparam int COUNT_WIDTH = $clog2(`MEM_LATENCY + 1);

    cpu_pkg::word_t mem_array [0:DEPTH-1];

    cpu_pkg::paddr_t        addr_q;
    logic                   busy;
    logic [COUNT_WIDTH-1:0] count;  // Cycles left until the response.
    logic                   accept;
    logic                   respond;

    assign mem_bus_available = !busy;
    assign accept            = mem_req_valid && mem_bus_available;
    assign respond           = busy && count == COUNT_WIDTH'(1);

    always_ff @(posedge clock) begin
        if (rst) begin
            busy           <= 1'b0;
            count          <= '0;
            mem_resp_valid <= 1'b0;
        end else begin
            mem_resp_valid <= respond;
            if (accept) begin
                busy  <= 1'b1;
                count <= COUNT_WIDTH'(`MEM_LATENCY - 1);
            end else if (busy) begin
                count <= count - 1'b1;
                busy  <= !respond;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q <= mem_req_addr;
            if (mem_req_write) begin
                mem_array[mem_req_addr] <= mem_req_data; // Written on acceptance.
            end
        end
        if (respond) begin
            mem_resp_data <= mem_array[addr_q];
        end
    end

endmodule

//--- logic/cpu_commit.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_commit (
    input  logic            clock,
    input  logic            rst,

    // Commit interface.
    input  logic            tlb_enable,
    input  logic            tlb_write,
    input  cpu_pkg::vpn_t   tlb_vpn,
    input  cpu_pkg::ppn_t   tlb_ppn,
    input  logic            cache_read,
    input  logic            cache_write,
    input  cpu_pkg::vaddr_t cache_addr,
    input  cpu_pkg::word_t  cache_data_in,
    output logic            commit_done,
    output logic            tlb_hit,
    output logic            cache_hit,
    output cpu_pkg::word_t  cache_data_out,

    // Memory bus, driven by the cache.
    output logic            mem_req_valid,
    output logic            mem_req_write,
    output cpu_pkg::paddr_t mem_req_addr,
    output cpu_pkg::word_t  mem_req_data,
    input  logic            mem_bus_available,
    input  logic            mem_resp_valid,
    input  cpu_pkg::word_t  mem_resp_data
);

    logic            lookup_hit;
    cpu_pkg::ppn_t   lookup_ppn;
    logic            access_ok;
    logic            fault_req;
    logic            fault_done;
    cpu_pkg::paddr_t req_addr;
    logic            req_read;
    logic            req_write;
    logic            cache_done;
    logic            cache_hit_raw;

    cpu_tlb tlb (
        .clock(clock),
        .rst(rst),
        .write(tlb_write),
        .write_vpn(tlb_vpn),
        .write_ppn(tlb_ppn),
        .lookup_vpn(cache_addr[`VIRTUAL_ADDR_WIDTH-1:`PAGE_OFFSET_WIDTH]),
        .hit(lookup_hit),
        .ppn(lookup_ppn)
    );

    assign access_ok = !tlb_enable || lookup_hit;
    assign fault_req = (cache_read || cache_write) && !access_ok;
    assign req_read  = cache_read && access_ok;
    assign req_write = cache_write && access_ok;
    assign req_addr  = tlb_enable ? {lookup_ppn, cache_addr[`PAGE_OFFSET_WIDTH-1:0]}
                                  : cache_addr[`PHYSICAL_ADDR_WIDTH-1:0];

    // Faulting access completes on its own with a single pulse.
    always_ff @(posedge clock) begin
        if (rst) begin
            fault_done <= 1'b0;
        end else begin
            fault_done <= fault_req && !fault_done;
        end
    end

    cpu_cache cache (
        .clock(clock),
        .rst(rst),
        .req_read(req_read),
        .req_write(req_write),
        .req_addr(req_addr),
        .req_data(cache_data_in),
        .done(cache_done),
        .hit(cache_hit_raw),
        .rdata(cache_data_out),
        .mem_req_valid(mem_req_valid),
        .mem_req_write(mem_req_write),
        .mem_req_addr(mem_req_addr),
        .mem_req_data(mem_req_data),
        .mem_bus_available(mem_bus_available),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp_data(mem_resp_data)
    );

    assign commit_done = fault_done || cache_done;
    assign tlb_hit     = access_ok;
    assign cache_hit   = cache_hit_raw && access_ok;

endmodule

//--- logic/cpu_mem_subsystem.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_mem_subsystem (
    input  logic            clock,
    input  logic            rst,
    input  logic            tlb_enable,
    input  logic            tlb_write,
    input  cpu_pkg::vpn_t   tlb_vpn,
    input  cpu_pkg::ppn_t   tlb_ppn,
    input  logic            cache_read,
    input  logic            cache_write,
    input  cpu_pkg::vaddr_t cache_addr,
    input  cpu_pkg::word_t  cache_data_in,
    output logic            commit_done,
    output logic            tlb_hit,
    output logic            cache_hit,
    output cpu_pkg::word_t  cache_data_out
);

    // Memory bus between cache and backing memory.
    logic            mem_req_valid;
    logic            mem_req_write;
    cpu_pkg::paddr_t mem_req_addr;
    cpu_pkg::word_t  mem_req_data;
    logic            mem_bus_available;
    logic            mem_resp_valid;
    cpu_pkg::word_t  mem_resp_data;

    cpu_commit commit (
        .clock(clock),
        .rst(rst),
        .tlb_enable(tlb_enable),
        .tlb_write(tlb_write),
        .tlb_vpn(tlb_vpn),
        .tlb_ppn(tlb_ppn),
        .cache_read(cache_read),
        .cache_write(cache_write),
        .cache_addr(cache_addr),
        .cache_data_in(cache_data_in),
        .commit_done(commit_done),
        .tlb_hit(tlb_hit),
        .cache_hit(cache_hit),
        .cache_data_out(cache_data_out),
        .mem_req_valid(mem_req_valid),
        .mem_req_write(mem_req_write),
        .mem_req_addr(mem_req_addr),
        .mem_req_data(mem_req_data),
        .mem_bus_available(mem_bus_available),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp_data(mem_resp_data)
    );

    cpu_main_memory main_memory (
        .clock(clock),
        .rst(rst),
        .mem_req_valid(mem_req_valid),
        .mem_req_write(mem_req_write),
        .mem_req_addr(mem_req_addr),
        .mem_req_data(mem_req_data),
        .mem_bus_available(mem_bus_available),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp_data(mem_resp_data)
    );

endmodule

//--- verification/cpu_mem_subsystem_tb.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_mem_subsystem_tb;

    localparam int CLOCK_PERIOD = 40;
    localparam int NUM_STEPS    = 25;
    localparam int SEED         = 59059;

    localparam logic [1:0] OP_FILL  = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_WRITE = 2'd2;

    logic            clock;
    logic            rst;
    logic            tlb_enable;
    logic            tlb_write;
    cpu_pkg::vpn_t   tlb_vpn;
    cpu_pkg::ppn_t   tlb_ppn;
    logic            cache_read;
    logic            cache_write;
    cpu_pkg::vaddr_t cache_addr;
    cpu_pkg::word_t  cache_data_in;
    logic            commit_done;
    logic            tlb_hit;
    logic            cache_hit;
    cpu_pkg::word_t  cache_data_out;

    // ######################################################################
    // Stimulus table
    // ######################################################################

    logic [1:0]      step_op         [NUM_STEPS];
    logic            step_en         [NUM_STEPS];
    cpu_pkg::vaddr_t step_addr       [NUM_STEPS];
    cpu_pkg::vpn_t   step_vpn        [NUM_STEPS];
    cpu_pkg::ppn_t   step_ppn        [NUM_STEPS];
    cpu_pkg::word_t  step_wdata      [NUM_STEPS];
    logic            step_exp_tlb    [NUM_STEPS];
    logic            step_exp_cache  [NUM_STEPS];
    cpu_pkg::word_t  step_exp_data   [NUM_STEPS];
    logic            step_check_data [NUM_STEPS];
    int              num_steps;
    int              current_step;

    cpu_mem_subsystem uut (
        .clock(clock),
        .rst(rst),
        .tlb_enable(tlb_enable),
        .tlb_write(tlb_write),
        .tlb_vpn(tlb_vpn),
        .tlb_ppn(tlb_ppn),
        .cache_read(cache_read),
        .cache_write(cache_write),
        .cache_addr(cache_addr),
        .cache_data_in(cache_data_in),
        .commit_done(commit_done),
        .tlb_hit(tlb_hit),
        .cache_hit(cache_hit),
        .cache_data_out(cache_data_out)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic add_fill(input cpu_pkg::vpn_t vpn, input cpu_pkg::ppn_t ppn);
        step_op[num_steps]         = OP_FILL;
        step_en[num_steps]         = 1'b0;
        step_addr[num_steps]       = '0;
        step_vpn[num_steps]        = vpn;
        step_ppn[num_steps]        = ppn;
        step_wdata[num_steps]      = '0;
        step_exp_tlb[num_steps]    = 1'b0;
        step_exp_cache[num_steps]  = 1'b0;
        step_exp_data[num_steps]   = '0;
        step_check_data[num_steps] = 1'b0;
        num_steps++;
    endtask

    task automatic add_access(input logic [1:0] op, input logic en, input cpu_pkg::vaddr_t addr,
                              input cpu_pkg::word_t wdata, input logic exp_tlb,
                              input logic exp_cache, input cpu_pkg::word_t exp_data,
                              input logic check_data);
        step_op[num_steps]         = op;
        step_en[num_steps]         = en;
        step_addr[num_steps]       = addr;
        step_vpn[num_steps]        = '0;
        step_ppn[num_steps]        = '0;
        step_wdata[num_steps]      = wdata;
        step_exp_tlb[num_steps]    = exp_tlb;
        step_exp_cache[num_steps]  = exp_cache;
        step_exp_data[num_steps]   = exp_data;
        step_check_data[num_steps] = check_data;
        num_steps++;
    endtask

    task automatic check_value(input string field, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: step %0d %s is %h, expected %h",
                     $time, current_step, field, actual, expected);
            $display("test failed");
            $fatal(1, "mismatch on %s", field);
        end
    endtask

    task automatic wait_for_done;
        @(negedge clock);
        while (commit_done !== 1'b1) @(negedge clock);
    endtask

    // ######################################################################
    // Main sequence
    // ######################################################################

    initial begin
        int unsigned gap;
        int unsigned seed_draw;
        tlb_enable    = 1'b0;
        tlb_write     = 1'b0;
        tlb_vpn       = '0;
        tlb_ppn       = '0;
        cache_read    = 1'b0;
        cache_write   = 1'b0;
        cache_addr    = '0;
        cache_data_in = '0;
        rst           = 1'b1;
        num_steps     = 0;
        current_step  = -1;
        seed_draw     = $urandom(SEED);

        add_access(OP_READ, 1'b1, 16'h0040, '0, 1'b0, 1'b0, '0, 1'b0); // Empty TLB faults.
        add_access(OP_WRITE, 1'b0, 16'h0005, 32'h11112222, 1'b1, 1'b0, '0, 1'b0);
        add_access(OP_READ, 1'b0, 16'h0005, '0, 1'b1, 1'b0, 32'h11112222, 1'b1); // No allocate.
        add_access(OP_READ, 1'b0, 16'h0005, '0, 1'b1, 1'b1, 32'h11112222, 1'b1);
        add_fill(10'h010, 6'h02);
        add_fill(10'h020, 6'h02);                                        // Alias page.
        add_access(OP_WRITE, 1'b1, 16'h0403, 32'hA5A50001, 1'b1, 1'b0, '0, 1'b0);
        add_access(OP_READ, 1'b1, 16'h0803, '0, 1'b1, 1'b0, 32'hA5A50001, 1'b1);
        add_access(OP_WRITE, 1'b0, 16'h000D, 32'h55556666, 1'b1, 1'b0, '0, 1'b0);
        add_access(OP_WRITE, 1'b0, 16'h0005, 32'h33334444, 1'b1, 1'b1, '0, 1'b0); // Write hit.
        add_access(OP_READ, 1'b0, 16'h0005, '0, 1'b1, 1'b1, 32'h33334444, 1'b1);
        add_access(OP_READ, 1'b0, 16'h000D, '0, 1'b1, 1'b0, 32'h55556666, 1'b1); // Evicts line 5.
        add_access(OP_READ, 1'b0, 16'h0005, '0, 1'b1, 1'b0, 32'h33334444, 1'b1);
        for (int v = 0; v < 5; v++) begin
            add_fill(cpu_pkg::vpn_t'(10'h100 + v), 6'h02);
        end
        add_access(OP_READ, 1'b1, 16'h4003, '0, 1'b0, 1'b0, '0, 1'b0); // Replaced entry.
        add_access(OP_READ, 1'b1, 16'h4043, '0, 1'b1, 1'b1, 32'hA5A50001, 1'b1);
        add_access(OP_READ, 1'b1, 16'h4083, '0, 1'b1, 1'b1, 32'hA5A50001, 1'b1);
        add_access(OP_READ, 1'b1, 16'h40C3, '0, 1'b1, 1'b1, 32'hA5A50001, 1'b1);
        add_access(OP_READ, 1'b1, 16'h4103, '0, 1'b1, 1'b1, 32'hA5A50001, 1'b1);
        add_access(OP_WRITE, 1'b1, 16'hF00D, 32'hDEADBEEF, 1'b0, 1'b0, '0, 1'b0);
        add_access(OP_READ, 1'b0, 16'h000D, '0, 1'b1, 1'b0, 32'h55556666, 1'b1); // Memory intact.

        repeat (2) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        check_value("commit_done", commit_done, 32'd0);

        for (int i = 0; i < num_steps; i++) begin
            current_step = i;
            @(negedge clock);
            if (step_op[i] == OP_FILL) begin
                tlb_write = 1'b1;
                tlb_vpn   = step_vpn[i];
                tlb_ppn   = step_ppn[i];
                @(negedge clock);
                tlb_write = 1'b0;
                check_value("commit_done", commit_done, 32'd0);
            end else begin
                tlb_enable    = step_en[i];
                cache_addr    = step_addr[i];
                cache_data_in = step_wdata[i];
                cache_read    = step_op[i] == OP_READ;
                cache_write   = step_op[i] == OP_WRITE;
                wait_for_done();
                check_value("tlb_hit", tlb_hit, step_exp_tlb[i]);
                check_value("cache_hit", cache_hit, step_exp_cache[i]);
                if (step_check_data[i]) begin
                    check_value("cache_data_out", cache_data_out, step_exp_data[i]);
                end
                cache_read  = 1'b0;
                cache_write = 1'b0;
            end
            gap = $urandom % 4;
            repeat (gap) @(negedge clock);
        end

        $display("test passed");
        $finish;
    end

    // Worst case per step is a memory round trip plus the idle gap.
    initial begin
        #(NUM_STEPS * (`MEM_LATENCY + 8) * CLOCK_PERIOD);
        $display("Timeout: commit_done never arrived for step %0d", current_step);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- compile.f
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_tlb.sv
logic/cpu_cache.sv
logic/cpu_main_memory.sv
logic/cpu_commit.sv
logic/cpu_mem_subsystem.sv
verification/cpu_mem_subsystem_tb.sv

//--- Bender.yml
package:
  name: cpu_mem_subsystem

export_include_dirs:
  - logic

sources:
  - logic/cpu_pkg.sv
  - logic/cpu_tlb.sv
  - logic/cpu_cache.sv
  - logic/cpu_main_memory.sv
  - logic/cpu_commit.sv
  - logic/cpu_mem_subsystem.sv
  - target: test
    files:
      - verification/cpu_mem_subsystem_tb.sv
